// File: obi_pkg.sv
// ******************************
// OBI bus types
// Request and response of the slave port
// ******************************

package obi_pkg;

  // Master to slave
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // Slave to master
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

endpackage

// File: reg_pkg.sv
// ******************************
// Register bus types
// Bus structs, address map and bridge states
// ******************************

package reg_pkg;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Page index from addr[11:8]
  typedef enum logic [3:0] {
    PAGE_GPIO  = 4'd0,
    PAGE_TIMER = 4'd1,
    PAGE_IRQ   = 4'd2
  } periph_page_e;

  localparam int NUM_PERIPH = 3;

  typedef enum logic [3:0] {
    GPIO_OUT    = 4'h0,
    GPIO_OUT_EN = 4'h4,
    GPIO_IN     = 4'h8,
    GPIO_INTR   = 4'hC
  } gpio_reg_e;

  typedef enum logic [3:0] {
    TMR_COUNT   = 4'h0,
    TMR_COMPARE = 4'h4,
    TMR_CTRL    = 4'h8,
    TMR_STATUS  = 4'hC
  } timer_reg_e;

  typedef enum logic [3:0] {
    IRQ_PENDING = 4'h0,
    IRQ_ENABLE  = 4'h4,
    IRQ_CLAIM   = 4'h8
  } irq_reg_e;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ACCESS,
    BR_RESPOND
  } bridge_state_e;

  // Byte strobes expanded to a bit mask
  function automatic logic [31:0] strb_to_mask(input logic [3:0] wstrb);
    logic [31:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{wstrb[b]}};
    end
    return mask;
  endfunction

endpackage

// File: obi_fifo.sv
// ******************************
// OBI request FIFO
// Buffers requests ahead of the bridge
// ******************************

`timescale 1ns/100ps

module obi_fifo #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  obi_pkg::obi_req_t  producer_req_i,
  output obi_pkg::obi_resp_t producer_resp_o,
  output obi_pkg::obi_req_t  consumer_req_o,
  input  obi_pkg::obi_resp_t consumer_resp_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  obi_pkg::obi_req_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign push  = producer_req_i.req && !full;
  assign pop   = consumer_resp_i.gnt && !empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= producer_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Head entry, req marks it valid
  always_comb begin
    consumer_req_o     = mem[rd_ptr];
    consumer_req_o.req = !empty;
  end

  // Response side passes through
  always_comb begin
    producer_resp_o        = consumer_resp_i;
    producer_resp_o.gnt    = !full;
  end

endmodule

// File: periph_to_reg.sv
// ******************************
// OBI to register bus bridge
// One register access in flight
// ******************************

`timescale 1ns/100ps

module periph_to_reg (
  input  logic               clk_i,
  input  logic               reset_i,
  input  obi_pkg::obi_req_t  obi_req_i,
  output obi_pkg::obi_resp_t obi_resp_o,
  output reg_pkg::reg_req_t  reg_req_o,
  input  reg_pkg::reg_rsp_t  reg_rsp_i
);

  reg_pkg::bridge_state_e state_q;
  reg_pkg::bridge_state_e state_d;
  reg_pkg::reg_req_t      req_q;
  logic [31:0]            rdata_q;
  logic                   err_q;
  logic                   accept;

  assign accept = (state_q == reg_pkg::BR_IDLE) && obi_req_i.req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      reg_pkg::BR_IDLE:    if (accept) state_d = reg_pkg::BR_ACCESS;
      reg_pkg::BR_ACCESS:  if (reg_rsp_i.ready) state_d = reg_pkg::BR_RESPOND;
      reg_pkg::BR_RESPOND: state_d = reg_pkg::BR_IDLE;
      default:             state_d = reg_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= reg_pkg::BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.valid <= 1'b1;
      req_q.write <= obi_req_i.we;
      req_q.wstrb <= obi_req_i.be;
      req_q.addr  <= obi_req_i.addr;
      req_q.wdata <= obi_req_i.wdata;
    end
    if (state_q == reg_pkg::BR_ACCESS && reg_rsp_i.ready) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  always_comb begin
    reg_req_o       = req_q;
    reg_req_o.valid = (state_q == reg_pkg::BR_ACCESS);
  end

  assign obi_resp_o.gnt    = accept;
  assign obi_resp_o.rvalid = (state_q == reg_pkg::BR_RESPOND);
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule

// File: reg_demux.sv
// ******************************
// Register bus demultiplexer
// Page decode, error reply for unmapped pages
// ******************************

`timescale 1ns/100ps

module reg_demux (
  input  reg_pkg::reg_req_t                        in_req_i,
  output reg_pkg::reg_rsp_t                        in_rsp_o,
  output reg_pkg::reg_req_t [reg_pkg::NUM_PERIPH-1:0] out_req_o,
  input  reg_pkg::reg_rsp_t [reg_pkg::NUM_PERIPH-1:0] out_rsp_i
);

  reg_pkg::periph_page_e page;

  assign page = reg_pkg::periph_page_e'(in_req_i.addr[11:8]);

  // Valid goes to the selected page only
  always_comb begin
    for (int i = 0; i < reg_pkg::NUM_PERIPH; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid && (page == i);
    end
  end

  always_comb begin
    case (page)
      reg_pkg::PAGE_GPIO,
      reg_pkg::PAGE_TIMER,
      reg_pkg::PAGE_IRQ: begin
        in_rsp_o = out_rsp_i[page];
      end
      default: begin
        // Unmapped, answer at once with an error
        in_rsp_o.ready = in_req_i.valid;
        in_rsp_o.error = 1'b1;
        in_rsp_o.rdata = '0;
      end
    endcase
  end

endmodule

// File: gpio_regs.sv
// ******************************
// GPIO registers
// Outputs, enables, synced inputs, edge interrupts
// ******************************

`timescale 1ns/100ps

module gpio_regs #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  reg_pkg::reg_req_t     reg_req_i,
  output reg_pkg::reg_rsp_t     reg_rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_en_o,
  output logic                  irq_o
);

  reg_pkg::gpio_reg_e    offset;
  logic                  wr_en;
  logic [31:0]           wmask;
  logic [GPIO_WIDTH-1:0] mask_g;
  logic [GPIO_WIDTH-1:0] wdata_g;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] en_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;
  logic [GPIO_WIDTH-1:0] intr_q;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] clr;
  logic [31:0]           rdata;

  assign offset  = reg_pkg::gpio_reg_e'(reg_req_i.addr[3:0]);
  assign wr_en   = reg_req_i.valid && reg_req_i.write;
  assign wmask   = reg_pkg::strb_to_mask(reg_req_i.wstrb);
  assign mask_g  = wmask[GPIO_WIDTH-1:0];
  assign wdata_g = reg_req_i.wdata[GPIO_WIDTH-1:0];
  assign rise    = sync2_q & ~prev_q;
  assign clr     = (wr_en && offset == reg_pkg::GPIO_INTR) ? (wdata_g & mask_g) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q   <= '0;
      en_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      intr_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && offset == reg_pkg::GPIO_OUT) begin
        out_q <= (out_q & ~mask_g) | (wdata_g & mask_g);
      end
      if (wr_en && offset == reg_pkg::GPIO_OUT_EN) begin
        en_q <= (en_q & ~mask_g) | (wdata_g & mask_g);
      end
      // New edges win over a clear in the same cycle
      intr_q <= (intr_q & ~clr) | rise;
    end
  end

  always_comb begin
    rdata = '0;
    case (offset)
      reg_pkg::GPIO_OUT:    rdata[GPIO_WIDTH-1:0] = out_q;
      reg_pkg::GPIO_OUT_EN: rdata[GPIO_WIDTH-1:0] = en_q;
      reg_pkg::GPIO_IN:     rdata[GPIO_WIDTH-1:0] = sync2_q;
      reg_pkg::GPIO_INTR:   rdata[GPIO_WIDTH-1:0] = intr_q;
      default:              rdata = '0;
    endcase
  end

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = rdata;

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;
  assign irq_o     = |intr_q;

endmodule

// File: timer_regs.sv
// ******************************
// Periodic compare timer
// Wraps on compare match, sets a flag
// ******************************

`timescale 1ns/100ps

module timer_regs (
  input  logic              clk_i,
  input  logic              reset_i,
  input  reg_pkg::reg_req_t reg_req_i,
  output reg_pkg::reg_rsp_t reg_rsp_o,
  output logic              irq_o
);

  reg_pkg::timer_reg_e offset;
  logic                wr_en;
  logic [31:0]         wmask;
  logic [31:0]         count_q;
  logic [31:0]         compare_q;
  logic                enable_q;
  logic                match_q;
  logic                hit;
  logic [31:0]         rdata;

  assign offset = reg_pkg::timer_reg_e'(reg_req_i.addr[3:0]);
  assign wr_en  = reg_req_i.valid && reg_req_i.write;
  assign wmask  = reg_pkg::strb_to_mask(reg_req_i.wstrb);
  assign hit    = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      match_q   <= 1'b0;
    end else begin
      // A count write overrides the increment
      if (wr_en && offset == reg_pkg::TMR_COUNT) begin
        count_q <= (count_q & ~wmask) | (reg_req_i.wdata & wmask);
      end else if (hit) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && offset == reg_pkg::TMR_COMPARE) begin
        compare_q <= (compare_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
      if (wr_en && offset == reg_pkg::TMR_CTRL && reg_req_i.wstrb[0]) begin
        enable_q <= reg_req_i.wdata[0];
      end
      if (hit) begin
        match_q <= 1'b1;
      end else if (wr_en && offset == reg_pkg::TMR_STATUS && reg_req_i.wstrb[0] &&
                   reg_req_i.wdata[0]) begin
        match_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (offset)
      reg_pkg::TMR_COUNT:   rdata = count_q;
      reg_pkg::TMR_COMPARE: rdata = compare_q;
      reg_pkg::TMR_CTRL:    rdata[0] = enable_q;
      reg_pkg::TMR_STATUS:  rdata[0] = match_q;
      default:              rdata = '0;
    endcase
  end

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = rdata;
  assign irq_o           = match_q;

endmodule

// File: irq_ctrl.sv
// ******************************
// Interrupt controller
// Pending, enable and claim to one core line
// ******************************

`timescale 1ns/100ps

module irq_ctrl #(
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  reg_pkg::reg_req_t        reg_req_i,
  output reg_pkg::reg_rsp_t        reg_rsp_o,
  input  logic [NUM_EXT_IRQ+2:0]   src_i,
  output logic                     irq_o
);

  localparam int NSRC = NUM_EXT_IRQ + 3;

  reg_pkg::irq_reg_e offset;
  logic              wr_en;
  logic [31:0]       wmask;
  logic [NSRC-1:0]   pending_q;
  logic [NSRC-1:0]   enable_q;
  logic [NSRC-1:0]   active;
  logic [31:0]       claim_id;
  logic [31:0]       rdata;

  assign offset = reg_pkg::irq_reg_e'(reg_req_i.addr[3:0]);
  assign wr_en  = reg_req_i.valid && reg_req_i.write;
  assign wmask  = reg_pkg::strb_to_mask(reg_req_i.wstrb);
  assign active = pending_q & enable_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= src_i;
      if (wr_en && offset == reg_pkg::IRQ_ENABLE) begin
        enable_q <= (enable_q & ~wmask[NSRC-1:0]) | (reg_req_i.wdata[NSRC-1:0] & wmask[NSRC-1:0]);
      end
    end
  end

  // Lowest active id, source 0 never fires
  always_comb begin
    claim_id = '0;
    for (int i = NSRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = 32'(i);
    end
  end

  always_comb begin
    rdata = '0;
    case (offset)
      reg_pkg::IRQ_PENDING: rdata[NSRC-1:0] = pending_q;
      reg_pkg::IRQ_ENABLE:  rdata[NSRC-1:0] = enable_q;
      reg_pkg::IRQ_CLAIM:   rdata = claim_id;
      default:              rdata = '0;
    endcase
  end

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = rdata;
  assign irq_o           = |active;

endmodule

// File: peripheral_subsystem.sv
// ******************************
// Peripheral subsystem
// OBI port to GPIO, timer and interrupts
// ******************************

`timescale 1ns/100ps

module peripheral_subsystem #(
  parameter int FIFO_DEPTH  = 2,
  parameter int GPIO_WIDTH  = 8,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  obi_pkg::obi_req_t      slave_req_i,
  output obi_pkg::obi_resp_t     slave_resp_o,
  input  logic [GPIO_WIDTH-1:0]  gpio_i,
  output logic [GPIO_WIDTH-1:0]  gpio_o,
  output logic [GPIO_WIDTH-1:0]  gpio_en_o,
  input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                   irq_o
);

  obi_pkg::obi_req_t  fifo_req;
  obi_pkg::obi_resp_t fifo_resp;
  reg_pkg::reg_req_t  periph_req;
  reg_pkg::reg_rsp_t  periph_rsp;

  reg_pkg::reg_req_t [reg_pkg::NUM_PERIPH-1:0] slv_req;
  reg_pkg::reg_rsp_t [reg_pkg::NUM_PERIPH-1:0] slv_rsp;

  logic                   gpio_irq;
  logic                   timer_irq;
  logic [NUM_EXT_IRQ+2:0] irq_src;

  // Source 0 is reserved
  assign irq_src = {ext_irq_i, timer_irq, gpio_irq, 1'b0};

  obi_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) obi_fifo_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .producer_req_i (slave_req_i),
    .producer_resp_o(slave_resp_o),
    .consumer_req_o (fifo_req),
    .consumer_resp_i(fifo_resp)
  );

  periph_to_reg periph_to_reg_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .obi_req_i (fifo_req),
    .obi_resp_o(fifo_resp),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i (periph_req),
    .in_rsp_o (periph_rsp),
    .out_req_o(slv_req),
    .out_rsp_i(slv_rsp)
  );

  gpio_regs #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio_regs_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(slv_req[reg_pkg::PAGE_GPIO]),
    .reg_rsp_o(slv_rsp[reg_pkg::PAGE_GPIO]),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .gpio_en_o(gpio_en_o),
    .irq_o    (gpio_irq)
  );

  timer_regs timer_regs_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(slv_req[reg_pkg::PAGE_TIMER]),
    .reg_rsp_o(slv_rsp[reg_pkg::PAGE_TIMER]),
    .irq_o    (timer_irq)
  );

  irq_ctrl #(
    .NUM_EXT_IRQ(NUM_EXT_IRQ)
  ) irq_ctrl_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(slv_req[reg_pkg::PAGE_IRQ]),
    .reg_rsp_o(slv_rsp[reg_pkg::PAGE_IRQ]),
    .src_i    (irq_src),
    .irq_o    (irq_o)
  );

endmodule

// File: tb_peripheral_subsystem.sv
// ******************************
// Peripheral subsystem testbench
// Replays bus operations from a data file over OBI
// ******************************

`timescale 1ns/100ps

module tb_peripheral_subsystem;

  localparam int FIFO_DEPTH    = 2;
  localparam int GPIO_WIDTH    = 8;
  localparam int NUM_EXT_IRQ   = 4;
  localparam int CYCLES_PER_OP = 200;

  logic                   clk_i;
  logic                   reset_i;
  obi_pkg::obi_req_t      slave_req_i;
  obi_pkg::obi_resp_t     slave_resp_o;
  logic [GPIO_WIDTH-1:0]  gpio_i;
  logic [GPIO_WIDTH-1:0]  gpio_o;
  logic [GPIO_WIDTH-1:0]  gpio_en_o;
  logic [NUM_EXT_IRQ-1:0] ext_irq_i;
  logic                   irq_o;

  // Operations from the data file
  string       op_name[$];
  string       op_kind[$];
  logic [31:0] op_addr[$];
  logic [31:0] op_data[$];
  logic [3:0]  op_strb[$];
  logic [31:0] op_exp[$];
  logic        op_err[$];

  // Responses still owed, oldest first
  string       exp_name[$];
  logic [31:0] exp_rdata[$];
  logic        exp_err[$];
  bit          exp_chk[$];

  int errors       = 0;
  int checks       = 0;
  int cycle_count  = 0;
  int limit_cycles = 0;

  peripheral_subsystem #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .GPIO_WIDTH (GPIO_WIDTH),
    .NUM_EXT_IRQ(NUM_EXT_IRQ)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .slave_req_i (slave_req_i),
    .slave_resp_o(slave_resp_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .ext_irq_i   (ext_irq_i),
    .irq_o       (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic load_ops();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] expv;
    logic [31:0] errv;
    fd = $fopen("periph_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open periph_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h", name, kind, addr, data, strb, expv, errv);
        if (n == 7) begin
          op_name.push_back(name);
          op_kind.push_back(kind);
          op_addr.push_back(addr);
          op_data.push_back(data);
          op_strb.push_back(strb[3:0]);
          op_exp.push_back(expv);
          op_err.push_back(errv[0]);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic check_response();
    string       name;
    logic [31:0] rdata;
    logic        err;
    bit          chk;
    if (exp_name.size() == 0) begin
      errors++;
      $display("rvalid arrived with no request outstanding");
    end else begin
      name  = exp_name.pop_front();
      rdata = exp_rdata.pop_front();
      err   = exp_err.pop_front();
      chk   = exp_chk.pop_front();
      if (chk) begin
        check_value(name, rdata, slave_resp_o.rdata);
      end
      check_value({name, " err"}, 32'(err), 32'(slave_resp_o.err));
    end
  endtask

  // One cycle; outputs are sampled on the falling edge
  task automatic step();
    @(negedge clk_i);
    if (!slave_resp_o.gnt && exp_name.size() < FIFO_DEPTH) begin
      errors++;
      $display("gnt low with only %0d requests in flight", exp_name.size());
    end
    if (exp_name.size() > FIFO_DEPTH + 1) begin
      errors++;
      $display("%0d requests in flight, more than the FIFO and bridge hold", exp_name.size());
    end
    if (slave_resp_o.rvalid) begin
      check_response();
    end
  endtask

  task automatic drain();
    while (exp_name.size() > 0) begin
      step();
    end
  endtask

  task automatic issue(input string name, input logic we, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be,
                       input logic [31:0] rdata, input logic err, input bit chk,
                       input bit expect_stall);
    bit stalled;
    stalled           = 1'b0;
    slave_req_i.req   = 1'b1;
    slave_req_i.we    = we;
    slave_req_i.be    = be;
    slave_req_i.addr  = addr;
    slave_req_i.wdata = wdata;
    while (!slave_resp_o.gnt) begin
      stalled = 1'b1;
      step();
    end
    // Granted, accepted at the coming rising edge
    exp_name.push_back(name);
    exp_rdata.push_back(rdata);
    exp_err.push_back(err);
    exp_chk.push_back(chk);
    step();
    slave_req_i.req = 1'b0;
    if (expect_stall && !stalled) begin
      errors++;
      $display("%s: gnt stayed high although the FIFO should be full", name);
    end
  endtask

  task automatic run_op(input int i);
    case (op_kind[i])
      "write": begin
        issue(op_name[i], 1'b1, op_addr[i], op_data[i], op_strb[i], op_exp[i], op_err[i],
              1'b0, 1'b0);
        drain();
      end
      "read": begin
        issue(op_name[i], 1'b0, op_addr[i], '0, op_strb[i], op_exp[i], op_err[i], 1'b1, 1'b0);
        drain();
      end
      "post_wr": issue(op_name[i], 1'b1, op_addr[i], op_data[i], op_strb[i], op_exp[i],
                       op_err[i], 1'b0, 1'b0);
      "post_rd": issue(op_name[i], 1'b0, op_addr[i], '0, op_strb[i], op_exp[i], op_err[i],
                       1'b1, 1'b0);
      "stall_rd": issue(op_name[i], 1'b0, op_addr[i], '0, op_strb[i], op_exp[i], op_err[i],
                        1'b1, 1'b1);
      "gpio":    gpio_i = op_data[i][GPIO_WIDTH-1:0];
      "ext":     ext_irq_i = op_data[i][NUM_EXT_IRQ-1:0];
      "wait":    repeat (op_data[i]) step();
      "drain":   drain();
      "pin_out": check_value(op_name[i], op_exp[i], 32'(gpio_o));
      "pin_en":  check_value(op_name[i], op_exp[i], 32'(gpio_en_o));
      "pin_irq": check_value(op_name[i], op_exp[i], 32'(irq_o));
      default: begin
        errors++;
        $display("%s: unknown operation %s", op_name[i], op_kind[i]);
      end
    endcase
  endtask

  initial begin
    reset_i     = 1'b1;
    slave_req_i = '0;
    gpio_i      = '0;
    ext_irq_i   = '0;
    load_ops();
    limit_cycles = CYCLES_PER_OP * op_name.size() + 32;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < op_name.size(); i++) begin
      run_op(i);
    end
    drain();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    wait (cycle_count >= limit_cycles);
    $display("timeout after %0d cycles, a grant or response never came", cycle_count);
    $display("test failed");
    $finish;
  end

endmodule

// File: periph_input.txt
# name op addr data strobe exp_rdata exp_err (all numbers hex, wait counts too)
# ops: write read post_wr post_rd stall_rd gpio ext wait drain pin_out pin_en pin_irq
out_wr     write    00000000 000000a5 f 00000000 0
out_strb   write    00000000 0000ff3c e 00000000 0
out_rd     read     00000000 00000000 f 000000a5 0
out_pin    pin_out  00000000 00000000 f 000000a5 0
en_wr      write    00000004 000000f0 f 00000000 0
en_rd      read     00000004 00000000 f 000000f0 0
en_pin     pin_en   00000000 00000000 f 000000f0 0
in_set     gpio     00000000 00000081 f 00000000 0
in_wait    wait     00000000 00000004 f 00000000 0
in_rd      read     00000008 00000000 f 00000081 0
intr_rd    read     0000000c 00000000 f 00000081 0
intr_clr   write    0000000c 00000081 f 00000000 0
intr_rd0   read     0000000c 00000000 f 00000000 0
tmr_cmp    write    00000104 00000014 f 00000000 0
tmr_en     write    00000108 00000001 f 00000000 0
tmr_wait   wait     00000000 0000001e f 00000000 0
tmr_stat   read     0000010c 00000000 f 00000001 0
tmr_dis    write    00000108 00000000 f 00000000 0
tmr_clr    write    0000010c 00000001 f 00000000 0
tmr_stat0  read     0000010c 00000000 f 00000000 0
irq_en     write    00000204 0000007a f 00000000 0
irq_gpio   gpio     00000000 00000083 f 00000000 0
irq_ext    ext      00000000 00000002 f 00000000 0
irq_wait   wait     00000000 00000006 f 00000000 0
irq_high   pin_irq  00000000 00000000 f 00000001 0
irq_pend   read     00000200 00000000 f 00000012 0
irq_claim  read     00000208 00000000 f 00000001 0
irq_gclr   write    0000000c 00000002 f 00000000 0
irq_claim4 read     00000208 00000000 f 00000004 0
irq_extlo  ext      00000000 00000000 f 00000000 0
irq_wait2  wait     00000000 00000004 f 00000000 0
irq_low    pin_irq  00000000 00000000 f 00000000 0
bad_wr     write    00000300 00000055 f 00000000 1
bad_rd     read     00000300 00000000 f 00000000 1
bad_chk    read     00000000 00000000 f 000000a5 0
burst_w    post_wr  00000000 00000011 f 00000000 0
burst_r1   post_rd  00000000 00000000 f 00000011 0
burst_r2   post_rd  00000104 00000000 f 00000014 0
burst_r3   stall_rd 00000000 00000000 f 00000011 0
burst_end  drain    00000000 00000000 f 00000000 0

// File: peripheral_subsystem.f
obi_pkg.sv
reg_pkg.sv
obi_fifo.sv
periph_to_reg.sv
reg_demux.sv
gpio_regs.sv
timer_regs.sv
irq_ctrl.sv
peripheral_subsystem.sv
tb_peripheral_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_peripheral_subsystem
FILELIST  ?= peripheral_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
